/* hdl/z80BusPkg.sv */
// --------------------
// Bus unit types: machine-cycle kinds, T-states
// bus widths and the Wishbone space field
// --------------------
package z80BusPkg;

    // Bus widths
    localparam int addrW    = 16;
    localparam int dataW    = 8;
    localparam int refreshW = 7;     // Refresh counter, bit 7 of addr stays low

    // Wishbone address layout
    localparam int wbKindLo = 16;
    localparam int wbKindHi = 17;
    localparam int wbAdrW   = wbKindHi + 1;

    localparam logic [1:0] spaceMem   = 2'd0;
    localparam logic [1:0] spaceIo    = 2'd1;
    localparam logic [1:0] spaceFetch = 2'd2;  // Opcode fetch space is read only

    // Machine-cycle function
    typedef enum logic [2:0] {
        cycFetch   = 3'd0,   // M1 cycle
        cycMRead   = 3'd1,
        cycMWrite  = 3'd2,
        cycIORead  = 3'd3,
        cycIOWrite = 3'd4,
        cycIdle    = 3'd7
    } busKindE;

    // T-state of the running machine cycle
    typedef enum logic [2:0] {
        tIdle = 3'd0,
        t1    = 3'd1,
        t2    = 3'd2,
        tW    = 3'd3,   // Wait state, automatic or nWAIT
        t3    = 3'd4,
        t4    = 3'd5    // Fetch only
    } tStateE;

endpackage

/* hdl/busCycleIntf.sv */
// --------------------
// Machine-cycle interface between the front end,
// sequencer, pin control and the bus pads
// --------------------
interface busCycleIntf;
    import z80BusPkg::*;

    // Request side, held by the front end until done
    logic             start;     // One clock, starts a machine cycle
    busKindE          kind;
    logic [addrW-1:0] addr;
    logic [dataW-1:0] wdata;

    // Sequencer state
    tStateE           tState;
    logic             inWait;    // High in any tW
    logic             done;      // Final T-state

    // Read data back from the pads
    logic [dataW-1:0] rdata;

    modport front (output start, kind, addr, wdata, input done, rdata);
    modport seq   (input start, kind, output tState, inWait, done);
    modport ctl   (input start, kind, tState, inWait);
    modport pads  (input addr, wdata, done, output rdata);

endinterface

/* hdl/wbFrontEnd.sv */
// --------------------
// Wishbone classic slave front end
// --------------------
module wbFrontEnd (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [z80BusPkg::wbAdrW-1:0] wbAdr,
    input  logic [z80BusPkg::dataW-1:0]  wbDatI,
    output logic [z80BusPkg::dataW-1:0]  wbDatO,
    output logic                         wbAck,
    busCycleIntf.front                   bus
);
    import z80BusPkg::*;

    logic       busy;      // One operation in flight
    logic       accept;
    logic [1:0] space;
    busKindE    reqKind;

    // New request only when idle and not in the ack clock
    assign accept = wbCyc && wbStb && !busy && !wbAck;
    assign space  = wbAdr[wbKindHi:wbKindLo];

    // Space and direction to cycle function
    always_comb begin
        case (space)
            spaceIo:    reqKind = wbWe ? cycIOWrite : cycIORead;
            spaceFetch: reqKind = wbWe ? cycMWrite  : cycFetch;   // Write here goes to memory
            spaceMem:   reqKind = wbWe ? cycMWrite  : cycMRead;
            default:    reqKind = wbWe ? cycMWrite  : cycMRead;   // Space 3 aliases memory
        endcase
    end

    // --------------------
    // Handshake state
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            bus.start <= 1'b0;
            bus.kind  <= cycIdle;
            wbAck     <= 1'b0;
        end else begin
            bus.start <= accept;       // Start one clock after accept
            wbAck     <= bus.done;     // Ack the clock after done
            if (accept) begin
                busy     <= 1'b1;
                bus.kind <= reqKind;
            end else if (wbAck) begin
                busy <= 1'b0;          // Free again after the ack clock
            end
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            bus.addr  <= wbAdr[addrW-1:0];
            bus.wdata <= wbDatI;
        end
        if (bus.done) begin
            wbDatO <= bus.rdata;       // Valid together with wbAck
        end
    end

endmodule

/* hdl/sequencer.sv */
// --------------------
// T-state sequencer with automatic I/O waits
// and nWAIT stretching
// --------------------
module sequencer #(
    parameter int unsigned ioAutoWait = 1   // Automatic tW states in I/O cycles
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     waitReq,   // Synchronized nWAIT, active high
    busCycleIntf.seq bus
);
    import z80BusPkg::*;

    localparam logic [1:0] ioWaits = 2'(ioAutoWait);

    tStateE     tNext;
    logic [1:0] autoCnt;        // Automatic waits still to run
    logic [1:0] autoNext;
    logic [1:0] firstWaits;     // Automatic waits for this kind
    logic       isIo;

    assign isIo       = (bus.kind == cycIORead) || (bus.kind == cycIOWrite);
    assign firstWaits = isIo ? ioWaits : 2'd0;

    // --------------------
    // Next T-state
    // --------------------
    always_comb begin
        tNext    = bus.tState;
        autoNext = autoCnt;
        case (bus.tState)
            tIdle: begin
                if (bus.start) begin
                    tNext = t1;
                end
            end
            t1: tNext = t2;
            t2: begin
                if (firstWaits != 2'd0) begin
                    tNext    = tW;
                    autoNext = firstWaits - 2'd1;   // This tW counts as the first
                end else if (waitReq) begin
                    tNext    = tW;
                    autoNext = 2'd0;
                end else begin
                    tNext = t3;
                end
            end
            tW: begin
                if (autoCnt != 2'd0) begin
                    autoNext = autoCnt - 2'd1;
                end else if (!waitReq) begin
                    tNext = t3;                      // Leave once nWAIT is released
                end
            end
            t3: tNext = (bus.kind == cycFetch) ? t4 : tIdle;
            t4: tNext = tIdle;
            default: tNext = tIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bus.tState <= tIdle;
            autoCnt    <= 2'd0;
        end else begin
            bus.tState <= tNext;
            autoCnt    <= autoNext;
        end
    end

    // Final T-state is T4 of a fetch or T3 of the rest
    assign bus.done   = (bus.tState == t4) ||
                        ((bus.tState == t3) && (bus.kind != cycFetch));
    assign bus.inWait = (bus.tState == tW);

endmodule

/* hdl/pinControl.sv */
// --------------------
// Strobe windows and pad enables from cycle
// function and T-state
// --------------------
module pinControl (
    input  logic     clk,
    input  logic     rstN,
    busCycleIntf.ctl bus,
    output logic     m1,
    output logic     mreq,
    output logic     iorq,
    output logic     rd,
    output logic     wr,
    output logic     rfsh,
    output logic     abWe,      // Load the address latch
    output logic     rfshSel,   // Refresh counter onto addr
    output logic     dbPinOe,   // Drive write data
    output logic     dbPinRe    // Sample dataIn
);
    import z80BusPkg::*;

    logic fFetch;     // Function flags, one hot
    logic fMRead;
    logic fMWrite;
    logic fIORead;
    logic fIOWrite;
    logic inT1;
    logic inT2;
    logic inT3;
    logic inT4;
    logic tA;         // T1 through the last tW
    logic tB;         // T2 through the last tW

    // Function latched at start, kept for the whole cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fFetch   <= 1'b0;
            fMRead   <= 1'b0;
            fMWrite  <= 1'b0;
            fIORead  <= 1'b0;
            fIOWrite <= 1'b0;
        end else if (bus.start) begin
            fFetch   <= (bus.kind == cycFetch);
            fMRead   <= (bus.kind == cycMRead);
            fMWrite  <= (bus.kind == cycMWrite);
            fIORead  <= (bus.kind == cycIORead);
            fIOWrite <= (bus.kind == cycIOWrite);
        end
    end

    assign inT1 = (bus.tState == t1);
    assign inT2 = (bus.tState == t2);
    assign inT3 = (bus.tState == t3);
    assign inT4 = (bus.tState == t4);
    assign tA   = inT1 || inT2 || bus.inWait;
    assign tB   = inT2 || bus.inWait;

    // --------------------
    // Strobes, active high
    // --------------------
    assign m1   = fFetch && tA;
    assign mreq = (fFetch && (tA || inT3 || inT4)) ||              // Fetch plus refresh
                  ((fMRead || fMWrite) && (tA || inT3));
    assign rd   = ((fFetch || fMRead) && tA) || (fMRead && inT3) ||
                  (fIORead && (tB || inT3));
    assign wr   = (fMWrite || fIOWrite) && (tB || inT3);            // Data settles in T1
    assign iorq = (fIORead || fIOWrite) && (tB || inT3);
    assign rfsh = fFetch && (inT3 || inT4);

    // Pad enables
    assign abWe    = inT1;
    assign rfshSel = fFetch && (inT3 || inT4);
    assign dbPinOe = (fMWrite || fIOWrite) && (tA || inT3);
    assign dbPinRe = (fFetch && tB) ||                           // Opcode taken before T3
                     ((fMRead || fIORead) && inT3);

endmodule

/* hdl/controlPins.sv */
// --------------------
// Registered active-low control pins
// and nWAIT synchronizer
// --------------------
module controlPins (
    input  logic clk,
    input  logic rstN,
    input  logic m1,
    input  logic mreq,
    input  logic iorq,
    input  logic rd,
    input  logic wr,
    input  logic rfsh,
    input  logic nWAIT,
    output logic nM1,
    output logic nMREQ,
    output logic nIORQ,
    output logic nRD,
    output logic nWR,
    output logic nRFSH,
    output logic waitReq
);
    logic [1:0] waitSync;   // Two-flop synchronizer, bit 1 is stable

    // Pins straight from flops, all high in reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            nM1      <= 1'b1;
            nMREQ    <= 1'b1;
            nIORQ    <= 1'b1;
            nRD      <= 1'b1;
            nWR      <= 1'b1;
            nRFSH    <= 1'b1;
            waitSync <= 2'b11;
        end else begin
            nM1      <= !m1;
            nMREQ    <= !mreq;
            nIORQ    <= !iorq;
            nRD      <= !rd;
            nWR      <= !wr;
            nRFSH    <= !rfsh;
            waitSync <= {waitSync[0], nWAIT};
        end
    end

    assign waitReq = !waitSync[1];   // Wait while the pin is low

endmodule

/* hdl/busPads.sv */
// --------------------
// Address latch, refresh counter, address mux
// and data-bus latches
// --------------------
module busPads (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        abWe,
    input  logic                        rfshSel,
    input  logic                        dbPinOe,
    input  logic                        dbPinRe,
    input  logic [z80BusPkg::dataW-1:0] dataIn,
    busCycleIntf.pads                   bus,
    output logic [z80BusPkg::addrW-1:0] addr,
    output logic [z80BusPkg::dataW-1:0] dataOut,
    output logic                        dataOe
);
    import z80BusPkg::*;

    logic [refreshW-1:0] rfshCnt;
    logic [addrW-1:0]    rfshAddr;
    logic [dataW-1:0]    dataLatch;   // Read data held after sampling

    // Upper byte and bit 7 stay low in refresh
    assign rfshAddr = {{(addrW - refreshW){1'b0}}, rfshCnt};

    // --------------------
    // Pin drivers and counter
    // --------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addr    <= '0;
            rfshCnt <= '0;
            dataOe  <= 1'b0;
        end else begin
            if (rfshSel) begin
                addr <= rfshAddr;
            end else if (abWe) begin
                addr <= bus.addr;
            end
            if (rfshSel && bus.done) begin
                rfshCnt <= rfshCnt + 1'b1;   // Once per fetch, wraps at 128
            end
            dataOe <= dbPinOe;               // Lines up with the strobe pins
        end
    end

    // Data latches
    always_ff @(posedge clk) begin
        if (abWe) begin
            dataOut <= bus.wdata;
        end
        if (dbPinRe) begin
            dataLatch <= dataIn;
        end
    end

    // Pin value passes through in the sampling clock
    assign bus.rdata = dbPinRe ? dataIn : dataLatch;

endmodule

/* hdl/z80BusTop.sv */
// --------------------
// Z80 bus interface unit, top level
// --------------------
module z80BusTop #(
    parameter int unsigned ioAutoWait = 1
) (
    input  logic                         clk,
    input  logic                         rstN,
    // Wishbone host
    input  logic                         wbCyc,
    input  logic                         wbStb,
    input  logic                         wbWe,
    input  logic [z80BusPkg::wbAdrW-1:0] wbAdr,
    input  logic [z80BusPkg::dataW-1:0]  wbDatI,
    output logic [z80BusPkg::dataW-1:0]  wbDatO,
    output logic                         wbAck,
    // Z80 control pins
    output logic                         nM1,
    output logic                         nMREQ,
    output logic                         nIORQ,
    output logic                         nRD,
    output logic                         nWR,
    output logic                         nRFSH,
    input  logic                         nWAIT,
    // Address and data
    output logic [z80BusPkg::addrW-1:0]  addr,
    input  logic [z80BusPkg::dataW-1:0]  dataIn,
    output logic [z80BusPkg::dataW-1:0]  dataOut,
    output logic                         dataOe
);
    logic m1;
    logic mreq;
    logic iorq;
    logic rd;
    logic wr;
    logic rfsh;
    logic abWe;
    logic rfshSel;
    logic dbPinOe;
    logic dbPinRe;
    logic waitReq;   // From the synchronizer

    busCycleIntf bus ();

    wbFrontEnd wbFrontEnd (.*, .bus(bus.front));

    sequencer #(.ioAutoWait(ioAutoWait)) sequencer (.*, .bus(bus.seq));

    pinControl pinControl (.*, .bus(bus.ctl));

    controlPins controlPins (.*);

    busPads busPads (.*, .bus(bus.pads));

endmodule

/* bench/busProtocol_chk.sv */
// --------------------
// Pin protocol assertions, bound to the top level
// --------------------
module busProtocol_chk (
    input logic clk,
    input logic rstN,
    input logic nM1,
    input logic nMREQ,
    input logic nIORQ,
    input logic nRD,
    input logic nWR,
    input logic nRFSH
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read and write strobes exclusive
    rdWrExcl: assert property (@(posedge clk) disable iff (!rstN) !(!nRD && !nWR))
        else $error("nRD and nWR low together");

    // Memory and I/O space exclusive
    mreqIorqExcl: assert property (@(posedge clk) disable iff (!rstN) !(!nMREQ && !nIORQ))
        else $error("nMREQ and nIORQ low together");

    rfshNotM1: assert property (@(posedge clk) disable iff (!rstN) !nRFSH |-> nM1)
        else $error("nRFSH low while nM1 low");

endmodule

/* bench/z80BusMon.sv */
// --------------------
// Monitor: expected memory, I/O and refresh
// model, Wishbone and pin checks
// --------------------
module z80BusMon (
    input logic        clk,
    input logic        rstN,
    input logic        wbStb,
    input logic        wbWe,
    input logic [17:0] wbAdr,
    input logic [7:0]  wbDatI,
    input logic [7:0]  wbDatO,
    input logic        wbAck,
    input logic        nM1,
    input logic        nMREQ,
    input logic        nIORQ,
    input logic        nRD,
    input logic        nWR,
    input logic        nRFSH,
    input logic        nWAIT,
    input logic [15:0] addr,
    input logic [7:0]  dataOut,
    input logic        dataOe
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] expMem [0:65535];
    logic [7:0] expIo  [0:255];
    logic [6:0] expRfsh;       // Wraps at 128
    logic       rfshSeen;
    logic       reqOpen;
    logic [7:0] expData;
    int         mismatchCount;
    int         otherCount;
    int         ackCount;
    int         reqCount;

    initial begin
        mismatchCount = 0;
        otherCount    = 0;
        ackCount      = 0;
        reqCount      = 0;
        expRfsh       = '0;
        rfshSeen      = 1'b0;
        reqOpen       = 1'b0;
        for (int i = 0; i < 65536; i++) expMem[i] = memFill(16'(i));
        for (int i = 0; i < 256; i++) expIo[i] = ioFill(8'(i));
    end

    function automatic logic [7:0] memFill(input logic [15:0] a);
        return a[7:0] ^ {a[14:8], a[15]} ^ 8'h5A;
    endfunction

    function automatic logic [7:0] ioFill(input logic [7:0] a);
        return ~a ^ 8'h33;
    endfunction

    task automatic mismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        mismatchCount++;
    endtask

    task automatic failNote(input string what);
        $display("ERROR: %s at %0t", what, $time);
        otherCount++;
    endtask

    // --------------------
    // Checks mid-cycle, where all pins are stable
    // --------------------
    always @(negedge clk) begin
        if (!rstN) begin
            if ({nM1, nMREQ, nIORQ, nRD, nWR, nRFSH} != 6'h3F)
                mismatch("nPins", {10'b0, nM1, nMREQ, nIORQ, nRD, nWR, nRFSH}, 16'h3F);
            if (dataOe) failNote("dataOe high during reset");
            if (wbAck) failNote("wbAck high during reset");
            expRfsh  = '0;
            rfshSeen = 1'b0;
        end else begin
            if (wbStb && !reqOpen) begin
                reqOpen = 1'b1;
                reqCount++;
            end
            if (!nM1 && (nMREQ || nRD))
                failNote("nM1 low without nMREQ and nRD low");
            if (!nIORQ) begin
                if (!nMREQ) failNote("nMREQ low during an I/O cycle");
                if (addr[7:0] !== wbAdr[7:0]) mismatch("addr[7:0]", addr, wbAdr[15:0]);
            end else if (nRFSH && (!nRD || !nWR) && addr !== wbAdr[15:0]) begin
                mismatch("addr", addr, wbAdr[15:0]);
            end
            if (!nWR) begin
                if (dataOut !== wbDatI) mismatch("dataOut", dataOut, wbDatI);
                if (!dataOe) failNote("dataOe low while nWR low");
            end
            // Refresh address, one count per fetch
            if (!nRFSH) begin
                if (nMREQ) failNote("nMREQ high during refresh");
                if (addr !== {9'b0, expRfsh}) mismatch("refresh addr", addr, {9'b0, expRfsh});
                rfshSeen = 1'b1;
            end else if (rfshSeen) begin
                expRfsh++;
                rfshSeen = 1'b0;
            end
            if (wbAck) begin
                ackCount++;
                reqOpen = 1'b0;
                if (ackCount != reqCount) failNote("ack does not match request order");
                if (!nWAIT) failNote("wbAck while nWAIT still low");
                if (wbWe) begin
                    if (wbAdr[17:16] == 2'd1) expIo[wbAdr[7:0]] = wbDatI;
                    else expMem[wbAdr[15:0]] = wbDatI;
                end else begin
                    expData = (wbAdr[17:16] == 2'd1) ? expIo[wbAdr[7:0]] : expMem[wbAdr[15:0]];
                    if (wbDatO !== expData) mismatch("wbDatO", wbDatO, expData);
                end
            end
        end
    end

endmodule

/* bench/z80BusTb.sv */
// --------------------
// Bench top: clock, reset, random Wishbone
// stimulus, memory and I/O device model
// --------------------
module z80BusTb;
    timeunit 1ns;
    timeprecision 100ps;
    import z80BusPkg::*;

    logic              clk;
    logic              rstN;
    logic              wbCyc;
    logic              wbStb;
    logic              wbWe;
    logic [wbAdrW-1:0] wbAdr;
    logic [dataW-1:0]  wbDatI;
    logic [dataW-1:0]  wbDatO;
    logic              wbAck;
    logic              nM1;
    logic              nMREQ;
    logic              nIORQ;
    logic              nRD;
    logic              nWR;
    logic              nRFSH;
    logic              nWAIT;
    logic [addrW-1:0]  addr;
    logic [dataW-1:0]  dataIn;
    logic [dataW-1:0]  dataOut;
    logic              dataOe;

    logic [dataW-1:0]  memArr [0:65535];   // Device memory
    logic [dataW-1:0]  ioArr  [0:255];     // Device I/O ports
    logic              wrIo;
    logic [addrW-1:0]  wrAddr;
    logic [dataW-1:0]  wrData;

    integer seed;
    logic   timedOut;
    int     opCount;

    z80BusTop #(.ioAutoWait(1)) DUT (.*);

    z80BusMon mon (.*);

    bind z80BusTop busProtocol_chk protoChk (.*);

    // Clock, 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Device model
    // --------------------
    assign dataIn = !nRD ? (!nIORQ ? ioArr[addr[7:0]] : memArr[addr]) : 8'h00;

    // Capture write while nWR low, commit on release
    always @(negedge clk) begin
        if (!nWR) begin
            wrIo   = !nIORQ;
            wrAddr = addr;
            wrData = dataOut;
        end
    end

    always @(posedge nWR) begin
        if (rstN) begin
            if (wrIo) ioArr[wrAddr[7:0]] = wrData;
            else memArr[wrAddr] = wrData;
        end
    end

    // Fill patterns, shared rule with the monitor
    function automatic logic [7:0] memFill(input logic [15:0] a);
        return a[7:0] ^ {a[14:8], a[15]} ^ 8'h5A;
    endfunction

    function automatic logic [7:0] ioFill(input logic [7:0] a);
        return ~a ^ 8'h33;
    endfunction

    // One Wishbone operation with nWAIT held low for a while
    task automatic runOp(input int kindSel, input logic [15:0] a,
                         input logic [7:0] d, input int waits);
        int         cycles;
        int         lowFor;
        logic [1:0] space;
        logic       we;
        we = (kindSel == 2) || (kindSel == 4) || (kindSel == 5);
        case (kindSel)
            1, 2:    space = spaceMem;
            3, 4:    space = spaceIo;
            default: space = spaceFetch;   // Kind 5 acts as memory write
        endcase
        lowFor = (waits == 0) ? 0 : waits + 2;
        @(posedge clk);
        #10;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = {space, a};
        wbDatI = d;
        if (lowFor > 0) nWAIT = 1'b0;
        cycles = 0;
        while (1) begin
            @(posedge clk);
            #10;
            cycles++;
            if (cycles >= lowFor) nWAIT = 1'b1;
            if (wbAck) break;
            if (cycles > 200) begin
                $display("Timeout: no Wishbone ack within 200 cycles of operation %0d",
                         opCount);
                timedOut = 1'b1;
                break;
            end
        end
        wbCyc = 1'b0;   // Address and data stay for the monitor
        wbStb = 1'b0;
        nWAIT = 1'b1;
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] a;
        int          pick;
        int          kindSel;
        int          waits;
        seed     = 30;
        timedOut = 1'b0;
        opCount  = 0;
        rstN     = 1'b0;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = '0;
        wbDatI   = '0;
        nWAIT    = 1'b1;
        wrIo     = 1'b0;
        wrAddr   = '0;
        wrData   = '0;
        for (int i = 0; i < 65536; i++) memArr[i] = memFill(16'(i));
        for (int i = 0; i < 256; i++) ioArr[i] = ioFill(8'(i));
        repeat (10) @(posedge clk);
        #10;
        rstN = 1'b1;

        // Mostly a small window so reads hit earlier writes
        for (opCount = 0; opCount < 300; opCount++) begin
            pick    = $unsigned($random(seed)) % 12;
            kindSel = (pick < 7) ? 0 : pick - 6;   // Fetch heavy, refresh count wraps
            r       = $random(seed);
            a       = (r[31:30] == 2'd0) ? r[15:0] : {10'b0, r[5:0]};
            waits   = $unsigned($random(seed)) % 4;
            runOp(kindSel, a, 8'($random(seed)), waits);
            if (timedOut) break;
        end
        repeat (5) @(posedge clk);

        $display("Errors: mismatches %0d, other %0d, timeouts %0d, acks %0d",
                 mon.mismatchCount, mon.otherCount, timedOut ? 1 : 0, mon.ackCount);
        if (timedOut || mon.mismatchCount != 0 || mon.otherCount != 0 ||
            mon.ackCount != 300) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/z80BusPkg.sv
hdl/busCycleIntf.sv
hdl/wbFrontEnd.sv
hdl/sequencer.sv
hdl/pinControl.sv
hdl/controlPins.sv
hdl/busPads.sv
hdl/z80BusTop.sv
bench/busProtocol_chk.sv
bench/z80BusMon.sv
bench/z80BusTb.sv

/* Bender.yml */
package:
  name: z80_bus

sources:
  - hdl/z80BusPkg.sv
  - hdl/busCycleIntf.sv
  - hdl/wbFrontEnd.sv
  - hdl/sequencer.sv
  - hdl/pinControl.sv
  - hdl/controlPins.sv
  - hdl/busPads.sv
  - hdl/z80BusTop.sv
  - target: simulation
    files:
      - bench/busProtocol_chk.sv
      - bench/z80BusMon.sv
      - bench/z80BusTb.sv
